/* Makefile */
VERILATOR ?= verilator
TOP       ?= mazeRobotTb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIMFLAGS  ?= +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIMFLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf $(BUILD_DIR)

/* list.f */
+incdir+logic
logic/robotPkg.sv
logic/trackSampler.sv
logic/mazeNavigator.sv
logic/turnStack.sv
logic/driveControl.sv
logic/mazeRobot.sv
tests/mazeRobot_assert.sv
tests/mazeRobotTb.sv

/* logic/driveControl.sv */
`timescale 1ns/100ps
`include "robot_settings.svh"

module driveControl (
    input  logic               clk,
    input  logic               rst,
    input  robotPkg::navState  state,
    input  robotPkg::trackWord track,
    input  logic               flash,
    input  logic [1:0]         countQuarter,
    output logic               in1,
    output logic               in2,
    output logic               in3,
    output logic               in4,
    output logic               leftPwm,
    output logic               rightPwm,
    output logic [15:0]        led
);
    localparam int PW = $clog2(`PWM_PERIOD);

    logic [PW-1:0] pwmCnt;
    logic [3:0]    dir;
    logic          leftSlow;
    logic          rightSlow;
    logic          slowPhase;
    logic [4:0]    lamp;
    logic [5:0]    motion;

    // {in1, in2, in3, in4}, left wheel on in1/in2 and right wheel on in3/in4
    always_comb begin
        case (state)
            robotPkg::STRAIGHT, robotPkg::LITTLE_LEFT, robotPkg::LITTLE_RIGHT: dir = 4'b1010;
            robotPkg::LEFT:  dir = 4'b0110;
            robotPkg::RIGHT: dir = 4'b1001;
            robotPkg::BACK:  dir = 4'b0101;
            default:         dir = 4'b0000;
        endcase
    end

    // Inner wheel runs at reduced duty while correcting
    assign leftSlow = (state == robotPkg::LITTLE_LEFT);
    assign rightSlow = (state == robotPkg::LITTLE_RIGHT);
    assign slowPhase = (pwmCnt < PW'(`PWM_SLOW));

    // State lamp on the top five LEDs
    always_comb begin
        case (state)
            robotPkg::START:        lamp = 5'b00001;
            robotPkg::COUNT:        lamp = 5'b00010;
            robotPkg::STRAIGHT:     lamp = 5'b01000;
            robotPkg::CHOOSE:       lamp = 5'b00111;
            robotPkg::LEFT:         lamp = 5'b10000;
            robotPkg::RIGHT:        lamp = 5'b00100;
            robotPkg::BACK:         lamp = 5'b01010;
            robotPkg::LITTLE_LEFT:  lamp = 5'b11000;
            robotPkg::LITTLE_RIGHT: lamp = 5'b01100;
            robotPkg::STOP:         lamp = 5'b11100;
            robotPkg::ERROR:        lamp = 5'b11111;
            default:                lamp = 5'b00000;
        endcase
    end

    // Motion field, the count-down bar shrinks one LED per quarter
    always_comb begin
        case (state)
            robotPkg::COUNT:        motion = flash ? 6'b000000 : (6'b111111 >> countQuarter);
            robotPkg::STRAIGHT:     motion = 6'b001100;
            robotPkg::LITTLE_LEFT:  motion = 6'b011000;
            robotPkg::LITTLE_RIGHT: motion = 6'b000110;
            robotPkg::LEFT:         motion = 6'b110000;
            robotPkg::RIGHT:        motion = 6'b000011;
            robotPkg::STOP:         motion = 6'b111111;
            robotPkg::BACK:         motion = flash ? 6'b000000 : 6'b111111;
            default:                motion = 6'b000000;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pwmCnt               <= '0;
            {in1, in2, in3, in4} <= 4'b0000;
            leftPwm              <= 1'b0;
            rightPwm             <= 1'b0;
            led                  <= '0;
        end else begin
            pwmCnt               <= (pwmCnt == PW'(`PWM_PERIOD - 1)) ? '0 : pwmCnt + 1'b1;
            {in1, in2, in3, in4} <= dir;
            leftPwm              <= (dir[3] | dir[2]) && (!leftSlow || slowPhase);
            rightPwm             <= (dir[1] | dir[0]) && (!rightSlow || slowPhase);
            led                  <= {lamp, 1'b0, motion, 1'b0, track.code};
        end
    end

endmodule

/* logic/mazeNavigator.sv */
`timescale 1ns/100ps
`include "robot_settings.svh"

module mazeNavigator (
    input  logic               clk,
    input  logic               rst,
    input  logic               run,
    input  robotPkg::trackWord track,
    input  logic               trackValid,
    input  robotPkg::turnEntry topEntry,
    output robotPkg::navState  state,
    output logic               push,
    output logic               replaceTop,
    output robotPkg::turnEntry newEntry,
    output logic               flash,
    output logic [1:0]         countQuarter
);
    localparam int TIMER_SPAN =
        (`COUNT_CYCLES > `STOP_CYCLES) ? `COUNT_CYCLES : `STOP_CYCLES;
    localparam int TW = $clog2(TIMER_SPAN);
    localparam int QUARTER = `COUNT_CYCLES / 4;
    localparam int FLASH_BIT = $clog2(`FLASH_CYCLES);

    robotPkg::navState nextState;
    robotPkg::navState resumeState;
    robotPkg::navState nextResume;
    logic [TW-1:0]     timer;
    logic              cpStraight;
    logic              cpChoose;
    logic              cpLeft;
    logic              cpRight;
    logic [1:0]        rightPasses;
    logic              doneRight;
    logic              prevFull;
    logic              fullMark;
    logic              onStraightPath;

    assign fullMark = (track.code == robotPkg::TURN_ROAD111);
    assign onStraightPath = (state == robotPkg::STRAIGHT) ||
                            (state == robotPkg::LITTLE_LEFT) ||
                            (state == robotPkg::LITTLE_RIGHT);
    assign doneRight = (rightPasses == 2'd2);

    // Shared timer drives the blink phase and the count-down quarters
    assign flash = timer[FLASH_BIT];
    assign countQuarter = 2'(timer / QUARTER);

    always_comb begin
        nextState  = state;
        nextResume = resumeState;
        push       = 1'b0;
        replaceTop = 1'b0;
        newEntry   = robotPkg::EMPTY;
        case (state)
            robotPkg::IDLE: begin
                nextState = robotPkg::START;
            end
            robotPkg::START: begin
                if (trackValid && track.code == robotPkg::STRAIGHT_ROAD) begin
                    nextState = robotPkg::COUNT;
                end
            end
            robotPkg::COUNT: begin
                if (timer == TW'(`COUNT_CYCLES - 1)) begin
                    nextState = robotPkg::STRAIGHT;
                end
            end
            robotPkg::STRAIGHT, robotPkg::LITTLE_LEFT, robotPkg::LITTLE_RIGHT: begin
                case (track.code)
                    robotPkg::RIGHT_ROAD, robotPkg::RIGHT_LITTLE_ROAD: begin
                        nextState = robotPkg::LITTLE_RIGHT;
                    end
                    robotPkg::LEFT_ROAD, robotPkg::LEFT_LITTLE_ROAD: begin
                        nextState = robotPkg::LITTLE_LEFT;
                    end
                    // Line lost, pause then back up
                    robotPkg::ERROR_ROAD: begin
                        nextState  = robotPkg::STOP;
                        nextResume = robotPkg::BACK;
                    end
                    robotPkg::TURN_ROAD111: begin
                        nextState = cpStraight ? robotPkg::CHOOSE : robotPkg::STRAIGHT;
                    end
                    default: begin
                        nextState = robotPkg::STRAIGHT;
                    end
                endcase
            end
            robotPkg::CHOOSE: begin
                if (track.code == robotPkg::TURN_ROAD101) begin
                    nextState  = robotPkg::STOP;
                    nextResume = robotPkg::LEFT;
                end else if (fullMark && cpChoose) begin
                    // Junction passed straight through, remember it
                    nextState = robotPkg::STRAIGHT;
                    push      = 1'b1;
                    newEntry  = robotPkg::TRIED_STRAIGHT;
                end
            end
            robotPkg::LEFT: begin
                if (fullMark && cpLeft) begin
                    nextState  = robotPkg::STOP;
                    nextResume = robotPkg::STRAIGHT;
                end
            end
            robotPkg::RIGHT: begin
                if (fullMark && cpRight && doneRight) begin
                    nextState  = robotPkg::STOP;
                    nextResume = robotPkg::STRAIGHT;
                end else if (track.code == robotPkg::TURN_ROAD101 && doneRight) begin
                    nextState = robotPkg::ERROR;
                end
            end
            robotPkg::BACK: begin
                // Back at the last junction, try the next untried branch
                if (fullMark) begin
                    case (topEntry)
                        robotPkg::TRIED_STRAIGHT: begin
                            nextState  = robotPkg::STOP;
                            nextResume = robotPkg::LEFT;
                            replaceTop = 1'b1;
                            newEntry   = robotPkg::TRIED_LEFT;
                        end
                        robotPkg::TRIED_LEFT: begin
                            nextState  = robotPkg::STOP;
                            nextResume = robotPkg::RIGHT;
                            replaceTop = 1'b1;
                            newEntry   = robotPkg::TRIED_RIGHT;
                        end
                        default: begin
                            nextState = robotPkg::ERROR;
                        end
                    endcase
                end
            end
            robotPkg::STOP: begin
                if (timer == TW'(`STOP_CYCLES - 1)) begin
                    nextState = resumeState;
                end
            end
            default: begin
                nextState = state;
            end
        endcase

        // Run switch low parks the robot and clears ERROR
        if (!run) begin
            nextState  = robotPkg::IDLE;
            push       = 1'b0;
            replaceTop = 1'b0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= robotPkg::IDLE;
            resumeState <= robotPkg::BACK;
            timer       <= '0;
            prevFull    <= 1'b0;
            cpStraight  <= 1'b0;
            cpChoose    <= 1'b0;
            cpLeft      <= 1'b0;
            cpRight     <= 1'b0;
            rightPasses <= 2'd0;
        end else begin
            state       <= nextState;
            resumeState <= nextResume;
            timer       <= (nextState != state) ? '0 : timer + 1'b1;
            prevFull    <= fullMark;

            // A mark counts only once the sensors left it inside this state
            cpStraight <= onStraightPath && (cpStraight || !fullMark);
            cpChoose   <= (state == robotPkg::CHOOSE) && (cpChoose || !fullMark);
            cpLeft     <= (state == robotPkg::LEFT) && (cpLeft || !fullMark);
            cpRight    <= (state == robotPkg::RIGHT) && (cpRight || !fullMark);

            // Rising passes onto the full mark during a right turn
            if (state != robotPkg::RIGHT) begin
                rightPasses <= 2'd0;
            end else if (cpRight && fullMark && !prevFull && !doneRight) begin
                rightPasses <= rightPasses + 1'b1;
            end
        end
    end

endmodule

/* logic/mazeRobot.sv */
`timescale 1ns/100ps

module mazeRobot (
    input  logic        clk,
    input  logic        rst,
    input  logic        run,
    input  logic        leftTrack,
    input  logic        midTrack,
    input  logic        rightTrack,
    output logic        in1,
    output logic        in2,
    output logic        in3,
    output logic        in4,
    output logic        leftPwm,
    output logic        rightPwm,
    output logic [15:0] led
);
    robotPkg::trackWord track;
    logic               trackValid;
    robotPkg::navState  state;
    logic               push;
    logic               replaceTop;
    robotPkg::turnEntry newEntry;
    robotPkg::turnEntry topEntry;
    logic               flash;
    logic [1:0]         countQuarter;

    trackSampler sampler (
        .clk        (clk),
        .rst        (rst),
        .leftTrack  (leftTrack),
        .midTrack   (midTrack),
        .rightTrack (rightTrack),
        .track      (track),
        .trackValid (trackValid)
    );

    mazeNavigator navigator (
        .clk          (clk),
        .rst          (rst),
        .run          (run),
        .track        (track),
        .trackValid   (trackValid),
        .topEntry     (topEntry),
        .state        (state),
        .push         (push),
        .replaceTop   (replaceTop),
        .newEntry     (newEntry),
        .flash        (flash),
        .countQuarter (countQuarter)
    );

    turnStack stack (
        .clk        (clk),
        .rst        (rst),
        .push       (push),
        .replaceTop (replaceTop),
        .newEntry   (newEntry),
        .topEntry   (topEntry)
    );

    driveControl drive (
        .clk          (clk),
        .rst          (rst),
        .state        (state),
        .track        (track),
        .flash        (flash),
        .countQuarter (countQuarter),
        .in1          (in1),
        .in2          (in2),
        .in3          (in3),
        .in4          (in4),
        .leftPwm      (leftPwm),
        .rightPwm     (rightPwm),
        .led          (led)
    );

endmodule

/* logic/robotPkg.sv */
package robotPkg;

    // Navigation states with their fixed encodings
    typedef enum logic [4:0] {
        IDLE         = 5'd0,
        START        = 5'd1,
        COUNT        = 5'd2,
        STRAIGHT     = 5'd3,
        CHOOSE       = 5'd4,
        LEFT         = 5'd5,
        RIGHT        = 5'd6,
        BACK         = 5'd7,
        LITTLE_LEFT  = 5'd8,
        LITTLE_RIGHT = 5'd9,
        STOP         = 5'd30,
        ERROR        = 5'd31
    } navState;

    // Sensor pattern read as a road shape with the left sensor in the MSB
    typedef enum logic [2:0] {
        ERROR_ROAD        = 3'b000,
        RIGHT_LITTLE_ROAD = 3'b001,
        STRAIGHT_ROAD     = 3'b010,
        RIGHT_ROAD        = 3'b011,
        LEFT_LITTLE_ROAD  = 3'b100,
        TURN_ROAD101      = 3'b101,
        LEFT_ROAD         = 3'b110,
        TURN_ROAD111      = 3'b111
    } roadCode;

    typedef struct packed {
        logic left;
        logic mid;
        logic right;
    } trackBits;

    // Same three bits written per sensor and read as a road code
    typedef union packed {
        trackBits bits;
        roadCode  code;
    } trackWord;

    typedef enum logic [1:0] {
        EMPTY          = 2'd0,
        TRIED_STRAIGHT = 2'd1,
        TRIED_LEFT     = 2'd2,
        TRIED_RIGHT    = 2'd3
    } turnEntry;

endpackage

/* logic/robot_settings.svh */
`ifndef ROBOT_SETTINGS_SVH
`define ROBOT_SETTINGS_SVH

// Equal synchronized samples needed before a sensor word is accepted
`define STABLE_CYCLES 4

// Count-down before the first move, split into four quarters
`define COUNT_CYCLES 64

// Pause length of the STOP state
`define STOP_CYCLES 32

// LED blink half-period while counting down or backing up
`define FLASH_CYCLES 8

// Turn memory entries
`define STACK_DEPTH 16

// Wheel PWM period and inner-wheel duty during a correction
`define PWM_PERIOD 16
`define PWM_SLOW 8

`endif

/* logic/trackSampler.sv */
`timescale 1ns/100ps
`include "robot_settings.svh"

module trackSampler (
    input  logic               clk,
    input  logic               rst,
    input  logic               leftTrack,
    input  logic               midTrack,
    input  logic               rightTrack,
    output robotPkg::trackWord track,
    output logic               trackValid
);
    localparam int CW = $clog2(`STABLE_CYCLES);

    robotPkg::trackBits sync1;
    robotPkg::trackBits sync2;
    logic [CW-1:0]      stableCnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sync1      <= '0;
            sync2      <= '0;
            stableCnt  <= '0;
            track      <= '0;
            trackValid <= 1'b0;
        end else begin
            // Two flops against metastability on the raw sensor pins
            sync1 <= '{left: leftTrack, mid: midTrack, right: rightTrack};
            sync2 <= sync1;

            // Any change restarts the stability count
            if (sync1 != sync2) begin
                stableCnt <= '0;
            end else if (stableCnt != CW'(`STABLE_CYCLES - 1)) begin
                stableCnt <= stableCnt + 1'b1;
            end else begin
                track.bits <= sync2;
                trackValid <= 1'b1;
            end
        end
    end

endmodule

/* logic/turnStack.sv */
`timescale 1ns/100ps
`include "robot_settings.svh"

module turnStack (
    input  logic               clk,
    input  logic               rst,
    input  logic               push,
    input  logic               replaceTop,
    input  robotPkg::turnEntry newEntry,
    output robotPkg::turnEntry topEntry
);
    localparam int AW = $clog2(`STACK_DEPTH);
    localparam int DW = $clog2(`STACK_DEPTH + 1);

    robotPkg::turnEntry entries [`STACK_DEPTH];
    logic [DW-1:0]      depth;
    logic [AW-1:0]      topIdx;
    logic               full;
    logic               empty;

    assign topIdx = AW'(depth - 1'b1);
    assign full = (depth == DW'(`STACK_DEPTH));
    assign empty = (depth == '0);
    assign topEntry = empty ? robotPkg::EMPTY : entries[topIdx];

    // Number of stored decisions, pushes beyond the last slot are dropped
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            depth <= '0;
        end else if (push && !full) begin
            depth <= depth + 1'b1;
        end
    end

    // Push fills the slot above the top, replace rewrites the top in place
    always_ff @(posedge clk) begin
        if (push && !full) begin
            entries[AW'(depth)] <= newEntry;
        end else if (replaceTop && !empty) begin
            entries[topIdx] <= newEntry;
        end
    end

endmodule

/* tests/mazeRobotTb.sv */
`timescale 1ns/100ps
`include "robot_settings.svh"

module mazeRobotTb;
    // Pin pattern to visible output change: sampler, navigator, drive register
    localparam int SETTLE_CYCLES = 4 + `STABLE_CYCLES;
    localparam int MAX_STEPS = 64;

    logic        clk;
    logic        rst;
    logic        run;
    logic        leftTrack;
    logic        midTrack;
    logic        rightTrack;
    logic        in1;
    logic        in2;
    logic        in3;
    logic        in4;
    logic        leftPwm;
    logic        rightPwm;
    logic [15:0] led;

    // One entry per line of the data file
    logic        stepRun   [MAX_STEPS];
    logic [2:0]  stepTrack [MAX_STEPS];
    int          stepHold  [MAX_STEPS];
    logic [3:0]  stepDir   [MAX_STEPS];
    logic [4:0]  stepLamp  [MAX_STEPS];

    int stepCount = 0;
    int cycleLimit = 0;
    int cycleCount = 0;
    int errorCount = 0;
    int testsRun = 0;
    int testsFailed = 0;

    mazeRobot UUT (
        .clk        (clk),
        .rst        (rst),
        .run        (run),
        .leftTrack  (leftTrack),
        .midTrack   (midTrack),
        .rightTrack (rightTrack),
        .in1        (in1),
        .in2        (in2),
        .in3        (in3),
        .in4        (in4),
        .leftPwm    (leftPwm),
        .rightPwm   (rightPwm),
        .led        (led)
    );

    always #20 clk = ~clk;

    // Run limit is set once the steps are loaded
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit > 0 && cycleCount > cycleLimit) begin
            $display("Timeout: the run went past %0d cycles without finishing", cycleLimit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    task automatic checkValue(input string name, input logic [15:0] actual,
                              input logic [15:0] expected);
        if (actual !== expected) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, actual, expected);
            errorCount++;
        end
    endtask

    task automatic reportTest(input string what, input int errorsBefore);
        testsRun++;
        if (errorCount != errorsBefore) begin
            testsFailed++;
            $display("test %0d (%s): fail", testsRun, what);
        end else begin
            $display("test %0d (%s): ok", testsRun, what);
        end
    endtask

    task automatic loadSteps();
        int         fd;
        int         fields;
        string      line;
        logic       runBit;
        logic [2:0] sensors;
        int         hold;
        logic [3:0] dir;
        logic [4:0] lamp;
        fd = $fopen("tests/mazeRobot_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open tests/mazeRobot_testdata.txt");
            errorCount++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                fields = $sscanf(line, "%b %b %d %b %b", runBit, sensors, hold, dir, lamp);
                // Comment and blank lines give fewer fields
                if (fields == 5) begin
                    if (stepCount >= MAX_STEPS) begin
                        $display("Data file has more than %0d steps", MAX_STEPS);
                        errorCount++;
                    end else begin
                        if (hold <= SETTLE_CYCLES) begin
                            $display("Step %0d holds %0d cycles, too short to settle",
                                     stepCount + 1, hold);
                            errorCount++;
                        end
                        stepRun[stepCount]   = runBit;
                        stepTrack[stepCount] = sensors;
                        stepHold[stepCount]  = hold;
                        stepDir[stepCount]   = dir;
                        stepLamp[stepCount]  = lamp;
                        stepCount++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic applyStep(input int idx);
        int errorsBefore;
        errorsBefore = errorCount;
        @(posedge clk);
        run        <= stepRun[idx];
        leftTrack  <= stepTrack[idx][2];
        midTrack   <= stepTrack[idx][1];
        rightTrack <= stepTrack[idx][0];
        repeat (stepHold[idx] - 1) @(posedge clk);
        // Outputs are sampled half a period away from the driving edge
        @(negedge clk);
        checkValue("in1..in4", 16'({in1, in2, in3, in4}), 16'(stepDir[idx]));
        checkValue("led[15:11]", 16'(led[15:11]), 16'(stepLamp[idx]));
        reportTest($sformatf("run %b sensors %b hold %0d", stepRun[idx], stepTrack[idx],
                             stepHold[idx]), errorsBefore);
    endtask

    initial begin
        int errorsBefore;
        int holdTotal;
        clk        = 1'b0;
        rst        = 1'b1;
        run        = 1'b0;
        leftTrack  = 1'b0;
        midTrack   = 1'b0;
        rightTrack = 1'b0;
        holdTotal  = 0;

        loadSteps();
        for (int i = 0; i < stepCount; i++) begin
            holdTotal += stepHold[i];
        end
        cycleLimit = 2 * holdTotal;

        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // Parked after reset, nothing driven and all lamps dark
        errorsBefore = errorCount;
        repeat (SETTLE_CYCLES) @(posedge clk);
        @(negedge clk);
        checkValue("in1..in4", 16'({in1, in2, in3, in4}), 16'h0000);
        checkValue("leftPwm", 16'(leftPwm), 16'h0000);
        checkValue("rightPwm", 16'(rightPwm), 16'h0000);
        checkValue("led", led, 16'h0000);
        reportTest("reset", errorsBefore);

        for (int i = 0; i < stepCount; i++) begin
            applyStep(i);
        end

        if (UUT.drive.safety.violations != 0) begin
            $display("Output safety assertions fired %0d times", UUT.drive.safety.violations);
            errorCount += UUT.drive.safety.violations;
        end

        $display("%0d tests run, %0d failed, %0d errors", testsRun, testsFailed, errorCount);
        if (errorCount == 0 && stepCount > 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* tests/mazeRobot_assert.sv */
`timescale 1ns/100ps

module mazeRobotAssert (
    input logic              clk,
    input logic              rst,
    input robotPkg::navState state,
    input logic              in1,
    input logic              in2,
    input logic              in3,
    input logic              in4,
    input logic              leftPwm,
    input logic              rightPwm
);
    int violations = 0;

    // Wheels get no power one cycle after a halted state
    haltedWheelsOff: assert property (@(posedge clk) disable iff (rst)
        (state == robotPkg::IDLE || state == robotPkg::STOP || state == robotPkg::ERROR)
            |=> (!leftPwm && !rightPwm))
    else begin
        $error("PWM active after IDLE, STOP or ERROR");
        violations++;
    end

    // Both H-bridge inputs of one wheel high would short the bridge
    leftBridgeSafe: assert property (@(posedge clk) disable iff (rst) !(in1 && in2))
    else begin
        $error("in1 and in2 high together");
        violations++;
    end

    rightBridgeSafe: assert property (@(posedge clk) disable iff (rst) !(in3 && in4))
    else begin
        $error("in3 and in4 high together");
        violations++;
    end

endmodule

bind driveControl mazeRobotAssert safety (
    .clk      (clk),
    .rst      (rst),
    .state    (state),
    .in1      (in1),
    .in2      (in2),
    .in3      (in3),
    .in4      (in4),
    .leftPwm  (leftPwm),
    .rightPwm (rightPwm)
);

/* tests/mazeRobot_testdata.txt */
// run  sensors(left mid right)  hold cycles  in1..in4  led[15:11]
// fields after the fifth are notes
0 010 12 0000 00000  idle with run low
1 010 20 0000 00010  count-down
1 010 60 1010 01000  straight
1 110 16 1010 11000  left road, little left
1 011 16 1010 01100  right road, little right
1 100 16 1010 11000  left edge, little left
1 001 16 1010 01100  right edge, little right
1 010 16 1010 01000  centered again
1 111 16 0000 00111  junction, choose
1 010 16 0000 00111  leave the mark
1 111 16 1010 01000  push straight
1 000 16 0000 11100  dead end, stop
1 000 40 0101 01010  backing
1 111 16 0000 11100  top straight becomes left
1 111 40 0110 10000  left spin
1 010 16 0110 10000  leave the mark
1 111 16 0000 11100  left turn done
1 111 40 1010 01000  straight
1 000 16 0000 11100  dead end again
1 000 40 0101 01010  backing
1 111 16 0000 11100  top left becomes right
1 111 40 1001 00100  right spin
1 010 16 1001 00100  leave the mark
1 111 16 1001 00100  first pass
1 010 16 1001 00100  between passes
1 111 16 0000 11100  second pass, stop
1 111 40 1010 01000  straight
1 000 16 0000 11100  third dead end
1 000 40 0101 01010  backing
1 111 16 0000 11111  all branches tried, error
0 111 16 0000 00000  run low clears error
